/* Makefile */
SIM := obj_dir/Vexec_unit_tb

$(SIM): verilog.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module exec_unit_tb -Mdir obj_dir

run: $(SIM) tests/exec_cases.txt
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test failures found" sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* rtl/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data path width of the execute block
`define XLEN 32

// Width of the immediate shift-amount field
`define SHAMT_W 5

// One quotient bit per divider step
`define DIV_STEPS `XLEN

`endif

/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    `include "alu_config.svh"

    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [4:0] {
        OP_AND   = 5'b00000,
        OP_OR    = 5'b00001,
        OP_XOR   = 5'b00010,
        OP_ADDU  = 5'b00011,
        OP_SUBU  = 5'b00100,
        OP_SLTU  = 5'b00101,
        OP_SLT   = 5'b00110,
        OP_MULTU = 5'b00111,
        OP_MULT  = 5'b01000,
        OP_SLL   = 5'b01001,
        OP_SLLV  = 5'b01010,
        OP_SRA   = 5'b01011,
        OP_SRL   = 5'b01100,
        OP_SRAV  = 5'b01101,
        OP_SRLV  = 5'b01110,
        OP_DIV   = 5'b01111,
        OP_DIVU  = 5'b10000,
        OP_MFHI  = 5'b10001,
        OP_MFLO  = 5'b10010,
        OP_BLTZ  = 5'b10011,
        OP_BGTZ  = 5'b10100,
        OP_BGEZ  = 5'b10101,
        OP_BNE   = 5'b10110,
        OP_BLEZ  = 5'b10111,
        OP_JR    = 5'b11000
    } alu_op_e;

    typedef enum logic [1:0] {
        MD_IDLE = 2'd0, // Waiting for start
        MD_MUL  = 2'd1, // Product held for HI/LO split
        MD_DIV  = 2'd2, // Shift-subtract steps
        MD_FIX  = 2'd3  // Quotient and remainder sign fix-up
    } md_state_e;

    // Ops that go to the multiply/divide unit instead of the ALU
    function automatic logic is_muldiv(alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    endfunction

endpackage

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_config.svh"

module exec_unit
    import alu_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  logic                in_valid,
    input  alu_op_e             op,
    input  word_t               a,
    input  word_t               b,
    input  logic [`SHAMT_W-1:0] shamt,
    output logic                out_valid,
    output word_t               y,
    output logic                zero,
    output logic                busy
);

    muldiv_if md_bus ();

    word_t alu_y;
    logic  alu_zero;
    logic  alu_issue;

    assign alu_issue    = in_valid && !is_muldiv(op);

    assign md_bus.start = in_valid && is_muldiv(op); // No back-pressure
    assign md_bus.op    = op;
    assign md_bus.a     = a;
    assign md_bus.b     = b;

    int_alu int_alu_inst (
        .op    (op),
        .a     (a),
        .b     (b),
        .shamt (shamt),
        .hi    (md_bus.hi),
        .lo    (md_bus.lo),
        .y     (alu_y),
        .zero  (alu_zero)
    );

    muldiv_unit muldiv_unit_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .md     (md_bus)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            y         <= '0;
            zero      <= 1'b1; // Matches y of zero
        end else begin
            out_valid <= alu_issue; // One cycle per issue
            if (alu_issue) begin
                y    <= alu_y;
                zero <= alu_zero;
            end
        end
    end

    assign busy = md_bus.busy;

endmodule

`default_nettype wire

/* rtl/int_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_config.svh"

module int_alu
    import alu_pkg::*;
(
    input  alu_op_e             op,
    input  word_t               a,
    input  word_t               b,
    input  logic [`SHAMT_W-1:0] shamt,
    input  word_t               hi,
    input  word_t               lo,
    output word_t               y,
    output logic                zero
);

    logic [`SHAMT_W-1:0] var_shamt;
    logic                a_neg;
    logic                a_is_zero;

    assign var_shamt = a[`SHAMT_W-1:0]; // Variable shifts use low bits of a
    assign a_neg     = a[`XLEN-1];
    assign a_is_zero = (a == '0);

    always_comb begin
        case (op)
            OP_AND: begin
                y = a & b;
            end
            OP_OR: begin
                y = a | b;
            end
            OP_XOR: begin
                y = a ^ b;
            end
            OP_ADDU: begin
                y = a + b;
            end
            OP_SUBU: begin
                y = a - b;
            end
            OP_SLTU: begin
                y = word_t'(a < b);
            end
            OP_SLT: begin
                y = word_t'($signed(a) < $signed(b));
            end
            OP_SLL: begin
                y = b << shamt;
            end
            OP_SLLV: begin
                y = b << var_shamt;
            end
            OP_SRA: begin
                y = $signed(b) >>> shamt; // Sign fill
            end
            OP_SRL: begin
                y = b >> shamt;
            end
            OP_SRAV: begin
                y = $signed(b) >>> var_shamt;
            end
            OP_SRLV: begin
                y = b >> var_shamt;
            end
            OP_MFHI: begin
                y = hi;
            end
            OP_MFLO: begin
                y = lo;
            end
            OP_BLTZ: begin
                y = word_t'(a_neg);
            end
            OP_BGTZ: begin
                y = word_t'(!a_neg && !a_is_zero);
            end
            OP_BGEZ: begin
                y = word_t'(!a_neg);
            end
            OP_BNE: begin
                y = word_t'(a != b);
            end
            OP_BLEZ: begin
                y = word_t'(a_neg || a_is_zero);
            end
            OP_JR: begin
                y = a; // Jump target passes through
            end
            default: begin
                y = '0; // Mul/div and unused codes
            end
        endcase
    end

    assign zero = (y == '0);

endmodule

`default_nettype wire

/* rtl/muldiv_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if
    import alu_pkg::*;
();

    logic    start; // One-cycle strobe, only while busy is low
    alu_op_e op;
    word_t   a;
    word_t   b;
    logic    busy;
    word_t   hi;
    word_t   lo;

    modport ctrl (
        output start, op, a, b,
        input  busy, hi, lo
    );

    modport unit (
        input  start, op, a, b,
        output busy, hi, lo
    );

endinterface

`default_nettype wire

/* rtl/muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_config.svh"

module muldiv_unit
    import alu_pkg::*;
(
    input wire      clk,
    input wire      arst_n,
    muldiv_if.unit  md
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    md_state_e          state_q;
    logic [CNT_W-1:0]   cnt_q;
    word_t              hi_q;
    word_t              lo_q;

    logic [2*`XLEN-1:0] prod_q;
    word_t              rem_q;
    word_t              quo_q;
    word_t              dvsr_q;
    logic               quo_neg_q;
    logic               rem_neg_q;

    logic               signed_op;
    logic               a_neg;
    logic               b_neg;
    word_t              a_mag;
    word_t              b_mag;
    logic [2*`XLEN-1:0] prod_mag;
    logic [2*`XLEN-1:0] prod;
    logic [`XLEN:0]     trial;

    assign signed_op = (md.op == OP_MULT) || (md.op == OP_DIV);
    assign a_neg     = signed_op && md.a[`XLEN-1];
    assign b_neg     = signed_op && md.b[`XLEN-1];
    assign a_mag     = a_neg ? (~md.a + 1'b1) : md.a;
    assign b_mag     = b_neg ? (~md.b + 1'b1) : md.b;

    assign prod_mag  = {{`XLEN{1'b0}}, a_mag} * {{`XLEN{1'b0}}, b_mag};
    assign prod      = (a_neg ^ b_neg) ? (~prod_mag + 1'b1) : prod_mag;

    // Partial remainder with next dividend bit, minus divisor
    assign trial     = {rem_q, quo_q[`XLEN-1]} - {1'b0, dvsr_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= MD_IDLE;
            cnt_q   <= '0;
            hi_q    <= '0;
            lo_q    <= '0;
        end else begin
            case (state_q)
                MD_IDLE: begin
                    if (md.start) begin
                        cnt_q <= '0;
                        if (md.op == OP_MULT || md.op == OP_MULTU) begin
                            state_q <= MD_MUL;
                        end else begin
                            state_q <= MD_DIV;
                        end
                    end
                end
                MD_MUL: begin
                    hi_q    <= prod_q[2*`XLEN-1:`XLEN];
                    lo_q    <= prod_q[`XLEN-1:0];
                    state_q <= MD_IDLE;
                end
                MD_DIV: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`DIV_STEPS - 1)) begin
                        state_q <= MD_FIX;
                    end
                end
                default: begin
                    lo_q    <= quo_neg_q ? (~quo_q + 1'b1) : quo_q;
                    hi_q    <= rem_neg_q ? (~rem_q + 1'b1) : rem_q;
                    state_q <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MD_IDLE && md.start) begin
            prod_q    <= prod;
            rem_q     <= '0;
            quo_q     <= a_mag; // Dividend shifts out as quotient shifts in
            dvsr_q    <= b_mag;
            // Zero divisor leaves quotient all ones and HI back at a
            quo_neg_q <= (a_neg ^ b_neg) && (md.b != '0);
            rem_neg_q <= a_neg;
        end else if (state_q == MD_DIV) begin
            if (!trial[`XLEN]) begin
                rem_q <= trial[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[`XLEN-2:0], quo_q[`XLEN-1]};
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign md.busy = (state_q != MD_IDLE);
    assign md.hi   = hi_q;
    assign md.lo   = lo_q;

endmodule

`default_nettype wire

/* tests/exec_cases.txt */
# op a b shamt exp1 exp2, all hex
# ALU ops: exp1 is y and exp2 the zero flag; mul/div ops: exp1 is HI and exp2 is LO
00 0f0f00ff 00ff0ff0 00 000f00f0 0
01 f0000000 0000000f 00 f000000f 0
02 a5a5a5a5 a5a5a5a5 00 00000000 1
03 ffffffff 00000001 00 00000000 1
03 12345678 11111111 00 23456789 0
04 00000000 00000001 00 ffffffff 0
05 00000001 ffffffff 00 00000001 0
06 00000001 ffffffff 00 00000000 1
06 ffffffff 00000001 00 00000001 0
09 00000000 00000001 1f 80000000 0
0a 00000024 0000000f 00 000000f0 0
0b 00000000 80000000 04 f8000000 0
0c 00000000 80000000 04 08000000 0
0d 00000008 f0000000 00 fff00000 0
0e 00000008 f0000000 00 00f00000 0
0c 00000000 12345678 00 12345678 0
13 80000000 00000000 00 00000001 0
13 00000005 00000000 00 00000000 1
14 00000005 00000000 00 00000001 0
14 00000000 00000000 00 00000000 1
15 00000000 00000000 00 00000001 0
16 00000005 00000005 00 00000000 1
17 ffffffff 00000000 00 00000001 0
18 00400020 00000000 00 00400020 0
07 ffffffff ffffffff 00 fffffffe 00000001
08 ffffffff 00000002 00 ffffffff fffffffe
08 fffffffd fffffff9 00 00000000 00000015
07 00010000 00010000 00 00000001 00000000
0f fffffff9 00000002 00 ffffffff fffffffd
0f 00000007 fffffffe 00 00000001 fffffffd
10 00000064 00000007 00 00000002 0000000e
10 12345678 00000000 00 12345678 ffffffff
0f fffffff9 00000000 00 fffffff9 ffffffff

/* tests/exec_unit_assert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_config.svh"

module exec_unit_assert
    import alu_pkg::*;
(
    input wire     clk,
    input wire     arst_n,
    input logic    in_valid,
    input alu_op_e op,
    input logic    out_valid,
    input logic    busy
);

    logic [7:0] busy_run; // Consecutive busy cycles

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_run <= '0;
        end else if (busy) begin
            busy_run <= busy_run + 8'd1;
        end else begin
            busy_run <= '0;
        end
    end

    no_issue_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> !busy)
        else $error("in_valid raised while the multiply/divide unit is busy");

    alu_result_next: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && !is_muldiv(op)) |=> out_valid)
        else $error("out_valid missing one cycle after an ALU issue");

    no_stray_result: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(in_valid && !is_muldiv(op)))
        else $error("out_valid raised without an ALU issue in the cycle before");

    busy_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        busy_run <= `DIV_STEPS + 2)
        else $error("busy held longer than a full divide");

endmodule

bind exec_unit exec_unit_assert exec_unit_assert_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .op        (op),
    .out_valid (out_valid),
    .busy      (busy)
);

`default_nettype wire

/* tests/exec_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_config.svh"

module exec_unit_tb
    import alu_pkg::*;
();

    localparam int N_RANDOM = 200;

    logic                clk;
    logic                arst_n;
    logic                in_valid;
    alu_op_e             op;
    word_t               a;
    word_t               b;
    logic [`SHAMT_W-1:0] shamt;
    logic                out_valid;
    word_t               y;
    logic                zero;
    logic                busy;

    alu_op_e             c_op[$];
    word_t               c_a[$];
    word_t               c_b[$];
    logic [`SHAMT_W-1:0] c_sh[$];
    word_t               c_e1[$]; // y, or HI for mul/div
    word_t               c_e2[$]; // zero flag, or LO for mul/div
    logic                loaded;
    logic [31:0]         rnd;

    exec_unit exec_unit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .shamt     (shamt),
        .out_valid (out_valid),
        .y         (y),
        .zero      (zero),
        .busy      (busy)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference results for the random ops
    function automatic word_t model_logic(input alu_op_e o, input word_t x, input word_t z);
        case (o)
            OP_AND:  return x & z;
            OP_OR:   return x | z;
            OP_XOR:  return x ^ z;
            OP_ADDU: return x + z;
            OP_SUBU: return x - z;
            default: return '0;
        endcase
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_sh;
        logic [31:0] f_e1;
        logic [31:0] f_e2;
        fd = $fopen("tests/exec_cases.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the cases file tests/exec_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_a, f_b, f_sh, f_e1, f_e2);
                if (n == 6) begin
                    c_op.push_back(alu_op_e'(f_op[4:0]));
                    c_a.push_back(f_a);
                    c_b.push_back(f_b);
                    c_sh.push_back(f_sh[`SHAMT_W-1:0]);
                    c_e1.push_back(f_e1);
                    c_e2.push_back(f_e2);
                end
            end
        end
        $fclose(fd);
        if (c_op.size() == 0) begin
            stop_on_error("no cases were found in tests/exec_cases.txt");
        end
    endtask

    task automatic drive_issue(input alu_op_e o, input word_t x, input word_t z,
                               input logic [`SHAMT_W-1:0] s);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = z;
        shamt    = s;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_hilo(input string name, input alu_op_e o, input word_t exp);
        drive_issue(o, '0, '0, '0);
        next_cycle();
        check_flag("out_valid", 1'b1, out_valid);
        check_word(name, exp, y);
        check_flag("zero", exp == '0, zero);
    endtask

    task automatic run_case(input int i);
        drive_issue(c_op[i], c_a[i], c_b[i], c_sh[i]);
        next_cycle();
        if (is_muldiv(c_op[i])) begin
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("busy", 1'b1, busy);
            wait_idle();
            read_hilo("hi", OP_MFHI, c_e1[i]);
            read_hilo("lo", OP_MFLO, c_e2[i]);
        end else begin
            check_flag("out_valid", 1'b1, out_valid);
            check_word("y", c_e1[i], y);
            check_flag("zero", c_e2[i][0], zero);
        end
    endtask

    // One issue per cycle with results back in order
    task automatic run_random();
        alu_op_e ops[5];
        word_t   exp_q[$];
        word_t   ra;
        word_t   rb;
        word_t   ey;
        alu_op_e ro;
        ops = '{OP_AND, OP_OR, OP_XOR, OP_ADDU, OP_SUBU};
        for (int i = 0; i <= N_RANDOM; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                check_flag("out_valid", 1'b1, out_valid);
                ey = exp_q.pop_front();
                check_word("y", ey, y);
                check_flag("zero", ey == '0, zero);
            end
            if (i < N_RANDOM) begin
                rnd = xorshift(rnd);
                ro  = ops[rnd % 5];
                rnd = xorshift(rnd);
                ra  = rnd;
                rnd = xorshift(rnd);
                rb  = rnd;
                in_valid = 1'b1;
                op       = ro;
                a        = ra;
                b        = rb;
                shamt    = '0;
                exp_q.push_back(model_logic(ro, ra, rb));
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = OP_AND;
        a        = '0;
        b        = '0;
        shamt    = '0;
        loaded   = 1'b0;
        rnd      = 32'd52;
        load_cases();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_flag("out_valid", 1'b0, out_valid); // Reset state
        check_flag("busy", 1'b0, busy);
        check_word("y", '0, y);
        check_flag("zero", 1'b1, zero);
        arst_n = 1'b1;
        for (int i = 0; i < c_op.size(); i++) begin
            run_case(i);
        end
        run_random();
        $display("All tests passed!");
        $finish;
    end

    // Budget of DIV_STEPS+8 cycles per case covers a divide plus two reads
    initial begin
        wait (loaded);
        repeat (10 + c_op.size() * (`DIV_STEPS + 8) + N_RANDOM + 20) @(posedge clk);
        stop_on_error("watchdog timeout, the simulation did not finish in time");
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/muldiv_if.sv
rtl/int_alu.sv
rtl/muldiv_unit.sv
rtl/exec_unit.sv
tests/exec_unit_assert.sv
tests/exec_unit_tb.sv
